/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // core word size
    localparam int word_width = 32;
    localparam int strb_width = word_width / 8;

    // data word or byte address
    typedef logic [word_width-1:0] word_t;

    // byte enables, bit 0 is the lowest byte lane
    typedef logic [strb_width-1:0] strb_t;

    // every lane on, used for instruction fetch
    localparam strb_t strb_all = '1;

    // top three address bits of the unmapped segments
    // kseg0 covers nibbles 8/9, kseg1 covers a/b
    localparam logic [2:0] kseg0_base = 3'b100;
    localparam logic [2:0] kseg1_base = 3'b101;

    // sram depth, 1024 words
    localparam int mem_words_log2 = 10;

    // instruction port request
    // held steady by the core until data_ok
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    // instruction port response, data_ok pulses once
    typedef struct packed {
        logic  data_ok;
        word_t data;
    } ibus_resp_t;

    // data port request
    typedef struct packed {
        logic  valid;
        logic  we;
        strb_t strb;
        word_t addr;
        word_t data;
    } dbus_req_t;

    // data port response
    // for a write only data_ok matters
    typedef struct packed {
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

endpackage

`default_nettype wire

/* src/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // classic wishbone, 32-bit data, byte granular select
    localparam int wb_adr_width = 32;
    localparam int wb_dat_width = 32;
    localparam int wb_sel_width = wb_dat_width / 8;

    // low address bits that pick a byte inside a word
    localparam int wb_byte_bits = $clog2(wb_sel_width);

    // masters on the shared bus
    // 0 is the instruction port, 1 is the data port
    localparam int wb_masters = 2;

    // physical byte address
    typedef logic [wb_adr_width-1:0] wb_adr_t;

    // bus data word
    typedef logic [wb_dat_width-1:0] wb_dat_t;

    // byte select
    typedef logic [wb_sel_width-1:0] wb_sel_t;

    // master to slave
    // cyc and stb stay up with stable fields until ack
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_sel_t sel;
        wb_adr_t adr;
        wb_dat_t dat_w;
    } wb_m2s_t;

    // slave to master
    // ack is a single cycle strobe, dat_r valid with it
    typedef struct packed {
        logic    ack;
        wb_dat_t dat_r;
    } wb_s2m_t;

endpackage

`default_nettype wire

/* src/mem_bus_port.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_bus_port
    import mips_pkg::*;
    import wb_pkg::*;
#(
    parameter bit do_addr_translation = 1'b1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  dbus_req_t  req,
    output dbus_resp_t resp,
    output wb_m2s_t    wb_m,
    input  wb_s2m_t    wb_s
);

    // idle waits for valid, bus holds the cycle, done pulses data_ok
    typedef enum logic [1:0] {
        idle,
        bus,
        done
    } state_t;

    state_t state_q;

    // physical address of the incoming request
    word_t paddr;

    // captured request, payload only
    wb_adr_t adr_q;
    wb_dat_t dat_q;
    wb_sel_t sel_q;
    logic    we_q;

    // read data latched on ack
    word_t rdata_q;

    // fixed kseg0/kseg1 mapping
    // top three bits cleared, bit 28 kept, so 8/a -> 0 and 9/b -> 1
    // everything else goes through untouched
    always_comb begin
        paddr = req.addr;
        if (do_addr_translation) begin
            if (req.addr[31:29] == kseg0_base || req.addr[31:29] == kseg1_base) begin
                paddr[31:29] = 3'b000;
            end
        end
    end

    // control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= idle;
        end else begin
            case (state_q)
                idle: begin
                    // sampled here, cyc goes up next cycle
                    if (req.valid) begin
                        state_q <= bus;
                    end
                end
                bus: begin
                    // stay until the slave answers
                    // also covers waiting for the grant
                    if (wb_s.ack) begin
                        state_q <= done;
                    end
                end
                done: begin
                    // core drops or changes valid after seeing data_ok
                    state_q <= idle;
                end
                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

    // request capture
    always_ff @(posedge clk) begin
        if (state_q == idle && req.valid) begin
            adr_q <= paddr;
            dat_q <= req.data;
            sel_q <= req.strb;
            we_q  <= req.we;
        end
    end

    // response capture
    always_ff @(posedge clk) begin
        if (state_q == bus && wb_s.ack) begin
            rdata_q <= wb_s.dat_r;
        end
    end

    // wishbone master side
    // cyc/stb fall in the cycle after ack as state leaves bus
    always_comb begin
        wb_m.cyc   = (state_q == bus);
        wb_m.stb   = (state_q == bus);
        wb_m.we    = we_q;
        wb_m.sel   = sel_q;
        wb_m.adr   = adr_q;
        wb_m.dat_w = dat_q;
    end

    // core side
    assign resp.data_ok = (state_q == done);
    assign resp.data    = rdata_q;

endmodule

`default_nettype wire

/* src/wb_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter
    import wb_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  wb_m2s_t [wb_masters-1:0]   m_req,
    output wb_s2m_t [wb_masters-1:0]   m_resp,
    output wb_m2s_t                    s_req,
    input  wb_s2m_t                    s_resp
);

    // cyc of every master
    logic [wb_masters-1:0] cyc_vec;

    // round-robin choice for a free bus
    logic rr_pick;

    // grant in effect this cycle
    logic grant;

    // owner while the bus is held
    logic grant_q;
    logic held_q;

    // owner of the last finished tenure
    logic last_q;

    always_comb begin
        for (int i = 0; i < wb_masters; i++) begin
            cyc_vec[i] = m_req[i].cyc;
        end
    end

    // both asking, give it to the one that did not have it last
    // otherwise whoever asks, master 1 only if it asks alone
    always_comb begin
        if (cyc_vec[0] && cyc_vec[1]) begin
            rr_pick = ~last_q;
        end else begin
            rr_pick = cyc_vec[1];
        end
    end

    // grant sticks while the owner keeps cyc up
    // once it drops cyc the bus is free again in that same cycle
    always_comb begin
        if (held_q && cyc_vec[grant_q]) begin
            grant = grant_q;
        end else begin
            grant = rr_pick;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q  <= 1'b0;
            grant_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            // held as long as the granted master has a cycle open
            held_q  <= cyc_vec[grant];
            grant_q <= grant;
            // tenure over, remember who had it
            if (held_q && !cyc_vec[grant_q]) begin
                last_q <= grant_q;
            end
        end
    end

    // granted master drives the slave
    assign s_req = m_req[grant];

    // read data goes to all, ack only to the owner
    always_comb begin
        for (int i = 0; i < wb_masters; i++) begin
            m_resp[i].dat_r = s_resp.dat_r;
            m_resp[i].ack   = s_resp.ack && (grant == i[0]);
        end
    end

endmodule

`default_nettype wire

/* src/wb_sram.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_sram
    import mips_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_m2s_t wb_m,
    output wb_s2m_t wb_s
);

    // word storage, no reset
    wb_dat_t mem [2**mem_words_log2];

    // word index, upper address bits dropped so the space wraps
    logic [mem_words_log2-1:0] word_idx;

    // new access, not the tail of an acked one
    logic access;

    logic    ack_q;
    wb_dat_t dat_r_q;

    assign word_idx = wb_m.adr[mem_words_log2+wb_byte_bits-1:wb_byte_bits];

    // ack low means this cycle is a fresh request
    assign access = wb_m.cyc && wb_m.stb && !ack_q;

    // one cycle ack
    // the master still has stb up while ack is high, so it must not retrigger
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // byte merge under sel
    always_ff @(posedge clk) begin
        if (access && wb_m.we) begin
            for (int b = 0; b < wb_sel_width; b++) begin
                if (wb_m.sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= wb_m.dat_w[b*8 +: 8];
                end
            end
        end
    end

    // read word comes out together with ack
    // a write returns the old word, masters ignore it
    always_ff @(posedge clk) begin
        if (access) begin
            dat_r_q <= mem[word_idx];
        end
    end

    assign wb_s.ack   = ack_q;
    assign wb_s.dat_r = dat_r_q;

endmodule

`default_nettype wire

/* src/cpu_mem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_mem_top
    import mips_pkg::*;
    import wb_pkg::*;
#(
    parameter bit do_addr_translation = 1'b1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ibus_req_t  ibus_req,
    output ibus_resp_t ibus_resp,
    input  dbus_req_t  dbus_req,
    output dbus_resp_t dbus_resp
);

    // instruction port seen as a read-only data port
    dbus_req_t  i_req;
    dbus_resp_t i_resp;

    // master side of the arbiter, index 0 inst, 1 data
    wb_m2s_t [wb_masters-1:0] m_req;
    wb_s2m_t [wb_masters-1:0] m_resp;

    // slave side
    wb_m2s_t s_req;
    wb_s2m_t s_resp;

    // fetch is always a full-word read
    assign i_req.valid = ibus_req.valid;
    assign i_req.we    = 1'b0;
    assign i_req.strb  = strb_all;
    assign i_req.addr  = ibus_req.addr;
    assign i_req.data  = '0;

    assign ibus_resp.data_ok = i_resp.data_ok;
    assign ibus_resp.data    = i_resp.data;

    mem_bus_port #(
        .do_addr_translation(do_addr_translation)
    ) i_port (
        .clk,
        .rst_n,
        .req  (i_req),
        .resp (i_resp),
        .wb_m (m_req[0]),
        .wb_s (m_resp[0])
    );

    mem_bus_port #(
        .do_addr_translation(do_addr_translation)
    ) d_port (
        .clk,
        .rst_n,
        .req  (dbus_req),
        .resp (dbus_resp),
        .wb_m (m_req[1]),
        .wb_s (m_resp[1])
    );

    // one bus for both ports
    wb_arbiter arbiter_i (
        .clk,
        .rst_n,
        .m_req,
        .m_resp,
        .s_req,
        .s_resp
    );

    wb_sram sram_i (
        .clk,
        .rst_n,
        .wb_m (s_req),
        .wb_s (s_resp)
    );

endmodule

`default_nettype wire

/* sim/mem_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_checker
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ibus_req_t  ibus_req,
    input  ibus_resp_t ibus_resp,
    input  dbus_req_t  dbus_req,
    input  dbus_resp_t dbus_resp,
    output int         data_errors,
    output int         timing_errors,
    output int         done_count
);

    localparam int depth = 2**mem_words_log2;
    localparam int max_latency = 7;
    localparam int plain_latency = 3;

    // shadow of the sram, plus which byte lanes hold a known value
    word_t shadow [depth];
    strb_t known [depth];

    // per port, index 0 inst, 1 data
    logic  busy [2];
    int    lat [2];
    logic  contended [2];
    logic  req_we [2];
    strb_t req_strb [2];
    word_t req_addr [2];
    word_t req_data [2];

    // port of the last completed transaction
    // each tenure is one transaction, so this is the last bus owner
    logic last_done;

    // both ports started together on a free bus
    logic tie_pending;
    logic tie_first;

    // kseg0 0x8000_0000..0x9fff_ffff and kseg1 0xa000_0000..0xbfff_ffff
    // both lose their top three bits, the rest is physical already
    function automatic int unsigned shadow_index(input word_t vaddr);
        word_t paddr;
        paddr = vaddr;
        if (vaddr >= 32'h8000_0000 && vaddr < 32'hc000_0000) begin
            paddr = vaddr & 32'h1fff_ffff;
        end
        // word index, upper bits wrap like the sram
        return (paddr >> 2) % depth;
    endfunction

    // byte enables to a bit mask
    function automatic word_t lane_mask(input strb_t s);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[b*8 +: 8] = {8{s[b]}};
        end
        return m;
    endfunction

    task automatic track_port(
        input int    p,
        input string name,
        input logic  valid,
        input logic  we,
        input strb_t strb,
        input word_t addr,
        input word_t wdata,
        input logic  data_ok,
        input word_t rdata,
        input logic  other_active
    );
        int unsigned idx;
        word_t       mask;
        if (busy[p]) begin
            lat[p]++;
            // the other port had the bus in play at some point
            if (other_active) begin
                contended[p] = 1'b1;
            end
        end
        if (data_ok) begin
            if (!busy[p]) begin
                $display("%s port gave a data_ok with no request pending at %0t", name, $time);
                timing_errors++;
            end else begin
                busy[p] = 1'b0;
                done_count++;
                if (!contended[p] && lat[p] != plain_latency) begin
                    $display("%s port took %0d cycles with the bus free, expected %0d",
                             name, lat[p], plain_latency);
                    timing_errors++;
                end
                idx = shadow_index(req_addr[p]);
                if (req_we[p]) begin
                    // merge only the enabled lanes
                    mask = lane_mask(req_strb[p]);
                    shadow[idx] = (shadow[idx] & ~mask) | (req_data[p] & mask);
                    known[idx]  = known[idx] | req_strb[p];
                end else begin
                    // lanes never written are not compared
                    mask = lane_mask(known[idx]);
                    if ((rdata & mask) !== (shadow[idx] & mask)) begin
                        $display("ERROR %s_resp.data addr %h: got %h expected %h lanes %h",
                                 name, req_addr[p], rdata, shadow[idx], known[idx]);
                        data_errors++;
                    end
                end
            end
        end else if (busy[p]) begin
            if (lat[p] > max_latency) begin
                $display("%s port got no data_ok within %0d cycles for address %h",
                         name, max_latency, req_addr[p]);
                timing_errors++;
                busy[p] = 1'b0;
            end
        end else if (valid) begin
            // new request, held by the core from here on
            busy[p]      = 1'b1;
            lat[p]       = 0;
            contended[p] = other_active;
            req_we[p]    = we;
            req_strb[p]  = strb;
            req_addr[p]  = addr;
            req_data[p]  = wdata;
        end
    endtask

    // falling edge, everything is settled here
    always @(negedge clk) begin : watch
        logic i_active;
        logic d_active;
        logic done_port;
        if (!rst_n) begin
            data_errors   = 0;
            timing_errors = 0;
            done_count    = 0;
            // arbiter leaves reset as if port 0 had the bus last
            last_done     = 1'b0;
            tie_pending   = 1'b0;
            tie_first     = 1'b0;
            for (int i = 0; i < 2; i++) begin
                busy[i]      = 1'b0;
                lat[i]       = 0;
                contended[i] = 1'b0;
            end
            for (int i = 0; i < depth; i++) begin
                known[i] = '0;
            end
        end else begin
            // taken before either port updates its own state
            i_active = busy[0] || ibus_req.valid;
            d_active = busy[1] || dbus_req.valid;
            // both raise cyc in the same cycle
            // the port that did not own the bus last goes first
            if (!busy[0] && !busy[1] && ibus_req.valid && dbus_req.valid) begin
                tie_pending = 1'b1;
                tie_first   = ~last_done;
            end
            track_port(0, "ibus", ibus_req.valid, 1'b0, strb_all, ibus_req.addr, '0,
                       ibus_resp.data_ok, ibus_resp.data, d_active);
            track_port(1, "dbus", dbus_req.valid, dbus_req.we, dbus_req.strb,
                       dbus_req.addr, dbus_req.data, dbus_resp.data_ok, dbus_resp.data,
                       i_active);
            if (ibus_resp.data_ok || dbus_resp.data_ok) begin
                done_port = dbus_resp.data_ok;
                if (tie_pending && done_port != tie_first) begin
                    $display("%s port was served first after both asked at once at %0t",
                             done_port ? "dbus" : "ibus", $time);
                    $display("the port that did not hold the bus last should have won");
                    timing_errors++;
                end
                tie_pending = 1'b0;
                last_done   = done_port;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top
    import mips_pkg::*;
();

    localparam int clk_period = 100;
    localparam int drive_delay = 10;
    localparam int window_words = 16;
    localparam int merge_rounds = 8;
    localparam int random_per_port = 100;
    // fill, alias write and two reads, merge pairs, fetch test, random phase
    localparam int planned_txns = window_words + 3 + 2*merge_rounds + 3 + 2*random_per_port;
    localparam int cycle_limit = 10*planned_txns + 50;

    logic       clk;
    logic       rst_n;
    ibus_req_t  ibus_req;
    ibus_resp_t ibus_resp;
    dbus_req_t  dbus_req;
    dbus_resp_t dbus_resp;

    int issued;
    int cycles;
    int data_errors;
    int timing_errors;
    int done_count;

    cpu_mem_top #(
        .do_addr_translation(1'b1)
    ) dut_i (
        .clk,
        .rst_n,
        .ibus_req,
        .ibus_resp,
        .dbus_req,
        .dbus_resp
    );

    mem_checker checker_i (
        .clk,
        .rst_n,
        .ibus_req,
        .ibus_resp,
        .dbus_req,
        .dbus_resp,
        .data_errors,
        .timing_errors,
        .done_count
    );

    initial clk = 1'b0;
    always #(clk_period/2) clk = ~clk;

    // run length guard
    initial cycles = 0;
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles, a request never completed", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // window of test words, seg picks kseg0, kseg1 or the unmapped view
    function automatic word_t window_addr(input int unsigned word, input int unsigned seg);
        word_t base;
        case (seg % 3)
            0: base = 32'h8000_0000;
            1: base = 32'ha000_0000;
            default: base = 32'h0000_0000;
        endcase
        return base | 32'h100 | ((word % window_words) << 2);
    endfunction

    // one data access, valid held until data_ok then dropped
    task automatic data_access(input logic we, input strb_t strb, input word_t addr,
                               input word_t data);
        @(posedge clk);
        #drive_delay;
        dbus_req.valid = 1'b1;
        dbus_req.we    = we;
        dbus_req.strb  = strb;
        dbus_req.addr  = addr;
        dbus_req.data  = data;
        issued++;
        do begin
            @(posedge clk);
            #drive_delay;
        end while (!dbus_resp.data_ok);
        dbus_req.valid = 1'b0;
    endtask

    // one instruction fetch
    task automatic fetch(input word_t addr);
        @(posedge clk);
        #drive_delay;
        ibus_req.valid = 1'b1;
        ibus_req.addr  = addr;
        issued++;
        do begin
            @(posedge clk);
            #drive_delay;
        end while (!ibus_resp.data_ok);
        ibus_req.valid = 1'b0;
    endtask

    task automatic random_fetches(input int n);
        for (int i = 0; i < n; i++) begin
            repeat ($urandom % 3) @(posedge clk);
            fetch(window_addr($urandom, $urandom));
        end
    endtask

    // mixed reads and strobed writes
    task automatic random_data(input int n);
        for (int i = 0; i < n; i++) begin
            repeat ($urandom % 3) @(posedge clk);
            data_access($urandom % 2, $urandom, window_addr($urandom, $urandom), $urandom);
        end
    endtask

    initial begin
        word_t       word;
        int unsigned idx;
        void'($urandom(32'ha5f7));
        rst_n    = 1'b0;
        ibus_req = '0;
        dbus_req = '0;
        issued   = 0;
        repeat (3) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        // quiet bus, any data_ok here is flagged by the checker
        repeat (5) @(posedge clk);

        // known contents for the window
        for (int i = 0; i < window_words; i++) begin
            data_access(1'b1, strb_all, window_addr(i, i), $urandom);
        end

        // kseg0 write, read back through kseg0 and the kseg1 alias
        word = $urandom;
        data_access(1'b1, strb_all, 32'h8000_0200, word);
        data_access(1'b0, strb_all, 32'h8000_0200, '0);
        data_access(1'b0, strb_all, 32'ha000_0200, '0);

        // partial writes merging into filled words
        for (int i = 0; i < merge_rounds; i++) begin
            idx = $urandom % window_words;
            data_access(1'b1, $urandom, window_addr(idx, $urandom), $urandom);
            data_access(1'b0, strb_all, window_addr(idx, $urandom), '0);
        end

        // fetch sees what the data port wrote, both views of the boot area
        data_access(1'b1, strb_all, 32'hbfc0_0010, $urandom);
        fetch(32'hbfc0_0010);
        fetch(32'h9fc0_0010);

        // both ports at once
        fork
            random_fetches(random_per_port);
            random_data(random_per_port);
        join

        repeat (5) @(posedge clk);
        $display("errors: data %0d, timing %0d, missing responses %0d",
                 data_errors, timing_errors, issued - done_count);
        if (data_errors == 0 && timing_errors == 0 && done_count == issued) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/mips_pkg.sv
src/wb_pkg.sv
src/mem_bus_port.sv
src/wb_arbiter.sv
src/wb_sram.sv
src/cpu_mem_top.sv
sim/mem_checker.sv
sim/tb_top.sv

/* Bender.yml */
package:
  name: cpu_mem

sources:
  - files:
      - src/mips_pkg.sv
      - src/wb_pkg.sv
      - src/mem_bus_port.sv
      - src/wb_arbiter.sv
      - src/wb_sram.sv
      - src/cpu_mem_top.sv
  - target: simulation
    files:
      - sim/mem_checker.sv
      - sim/tb_top.sv
